// ==== hw/core_pkg.sv ====
package core_pkg;

	// ------------------------------------------------------------
	// widths and fixed values
	// ------------------------------------------------------------
	localparam int xlen = 32;
	localparam int reg_count = 16;

	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [$clog2(reg_count)-1:0] reg_id_t;
	typedef logic [1:0] axi_resp_t;

	localparam addr_t reset_pc = 32'h0000_0000;
	localparam axi_resp_t axi_okay = 2'b00;

	// major opcodes of the supported subset
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_branch = 7'b1100011;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	// ------------------------------------------------------------
	// stage payloads
	// ------------------------------------------------------------
	typedef struct packed {
		addr_t pc;
		inst_t inst;
	} fetch_pkt_t;

	typedef struct packed {
		addr_t   pc;
		word_t   operand_a;
		word_t   operand_b;
		word_t   branch_rhs;   // rs2 value for the compare
		word_t   imm;
		alu_op_e alu_op;
		reg_id_t rd;
		logic    reg_write;
		logic    is_branch;
		logic    branch_ne;
		logic    is_jal;
	} exec_pkt_t;

	typedef struct packed {
		addr_t   pc;
		reg_id_t rd;
		logic    reg_write;
		word_t   result;
	} wb_pkt_t;

	typedef struct packed {
		logic    valid;
		addr_t   pc;
		reg_id_t rd;
		logic    reg_write;
		word_t   data;
	} retire_t;

	// forwarding source, valid only for a live register write
	typedef struct packed {
		logic    valid;
		reg_id_t rd;
		word_t   data;
	} bypass_t;

endpackage

// ==== hw/pipe_stage.sv ====
module pipe_stage #(
	parameter int width = 32
) (
	input  logic             clock,
	input  logic             arst_n,
	input  logic             flush,
	input  logic             in_valid,
	output logic             in_ready,
	input  logic [width-1:0] in_data,
	output logic             out_valid,
	input  logic             out_ready,
	output logic [width-1:0] out_data
);
	logic             valid_q;
	logic [width-1:0] data_q;

	// free slot, or the current entry leaves this cycle
	assign in_ready = !valid_q || out_ready;
	assign out_valid = valid_q;
	assign out_data = data_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	a_hold_stable: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 flush,
	input  core_pkg::addr_t      flush_target,
	output logic                 ar_valid,
	output core_pkg::addr_t      ar_addr,
	input  logic                 ar_ready,
	input  logic                 r_valid,
	input  core_pkg::word_t      r_data,
	input  core_pkg::axi_resp_t  r_resp,
	output logic                 r_ready,
	output logic                 out_valid,
	input  logic                 out_ready,
	output core_pkg::fetch_pkt_t out_pkt
);
	typedef enum logic [1:0] {
		st_request,
		st_wait_data,
		st_hold
	} fetch_state_e;

	fetch_state_e    state_q;
	fetch_state_e    state_d;
	core_pkg::addr_t pc_q;
	core_pkg::addr_t pc_d;
	core_pkg::addr_t req_addr_q;
	core_pkg::addr_t req_addr_d;
	logic            stale_q;
	logic            stale_d;
	logic            ar_valid_q;
	core_pkg::inst_t inst_q;
	logic            ar_fire;
	logic            r_fire;
	logic            out_fire;

	assign ar_fire = ar_valid_q && ar_ready;
	assign r_fire = r_valid && r_ready;
	assign out_fire = out_valid && out_ready;

	assign ar_valid = ar_valid_q;
	assign ar_addr = req_addr_q;
	assign r_ready = (state_q == st_wait_data);
	assign out_valid = (state_q == st_hold);
	assign out_pkt.pc = pc_q;
	assign out_pkt.inst = inst_q;

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		pc_d = pc_q;
		req_addr_d = req_addr_q;
		stale_d = stale_q;
		case (state_q)
			st_request: begin
				if (ar_fire) begin
					state_d = st_wait_data;
				end
			end
			st_wait_data: begin
				if (r_fire && stale_q) begin
					// dropped beat, refetch at the redirected pc
					state_d = st_request;
					req_addr_d = pc_q;
					stale_d = 1'b0;
				end else if (r_fire) begin
					state_d = st_hold;
				end
			end
			default: begin
				if (out_fire) begin
					state_d = st_request;
					pc_d = pc_q + 32'd4;
					req_addr_d = pc_q + 32'd4;
				end
			end
		endcase
		// redirect; a read already on the bus must still complete
		if (flush) begin
			pc_d = flush_target;
			case (state_q)
				st_request: stale_d = 1'b1;
				st_wait_data: begin
					if (r_fire) begin
						state_d = st_request;
						req_addr_d = flush_target;
						stale_d = 1'b0;
					end else begin
						stale_d = 1'b1;
					end
				end
				default: begin
					state_d = st_request;
					req_addr_d = flush_target;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_request;
			pc_q <= core_pkg::reset_pc;
			req_addr_q <= core_pkg::reset_pc;
			stale_q <= 1'b0;
			ar_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			pc_q <= pc_d;
			req_addr_q <= req_addr_d;
			stale_q <= stale_d;
			// low in reset, so the first request shows one edge later
			ar_valid_q <= (state_d == st_request);
		end
	end

	// error response turns into an all-zero word, which decodes as no-write
	always_ff @(posedge clock) begin
		if (r_fire && !stale_q) begin
			inst_q <= (r_resp == core_pkg::axi_okay) ? r_data : '0;
		end
	end

	a_ar_stable: assert property (@(posedge clock) disable iff (!arst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
	input  logic              clock,
	input  logic              arst_n,
	input  core_pkg::reg_id_t rs1,
	input  core_pkg::reg_id_t rs2,
	output core_pkg::word_t   rdata1,
	output core_pkg::word_t   rdata2,
	input  logic              we,
	input  core_pkg::reg_id_t wa,
	input  core_pkg::word_t   wd
);
	// x1 .. x15, x0 has no storage
	core_pkg::word_t [core_pkg::reg_count-1:1] regs_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			regs_q <= '0;
		end else if (we && wa != '0) begin
			regs_q[wa] <= wd;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs_q[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs_q[rs2];

	a_no_x0_write: assert property (@(posedge clock) disable iff (!arst_n)
		we && wa == '0 |=> $stable(regs_q));

endmodule

// ==== hw/decode_unit.sv ====
module decode_unit (
	input  logic                 in_valid,
	output logic                 in_ready,
	input  core_pkg::fetch_pkt_t in_pkt,
	output core_pkg::reg_id_t    rs1,
	output core_pkg::reg_id_t    rs2,
	input  core_pkg::word_t      rdata1,
	input  core_pkg::word_t      rdata2,
	input  core_pkg::bypass_t    ex_bypass,
	input  core_pkg::bypass_t    wb_bypass,
	output logic                 out_valid,
	input  logic                 out_ready,
	output core_pkg::exec_pkt_t  out_pkt
);
	core_pkg::inst_t inst;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	core_pkg::word_t imm_i;
	core_pkg::word_t imm_u;
	core_pkg::word_t imm_j;
	core_pkg::word_t imm_b;
	core_pkg::word_t imm_sel;
	core_pkg::word_t src1;
	core_pkg::word_t src2;
	logic            use_imm;
	// rv32e has x0..x15, a set top bit in a register field is illegal
	logic            r_ok;
	logic            i_ok;
	logic            u_ok;
	logic            b_ok;

	// youngest producer wins
	function automatic core_pkg::word_t pick_operand(
		input core_pkg::reg_id_t idx,
		input core_pkg::word_t   rf_data,
		input core_pkg::bypass_t ex,
		input core_pkg::bypass_t wb
	);
		core_pkg::word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (ex.valid && ex.rd == idx) begin
			val = ex.data;
		end else if (wb.valid && wb.rd == idx) begin
			val = wb.data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	assign in_ready = out_ready;
	assign out_valid = in_valid;

	assign inst = in_pkt.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1 = inst[18:15];
	assign rs2 = inst[23:20];

	assign r_ok = !inst[11] && !inst[19] && !inst[24];
	assign i_ok = !inst[11] && !inst[19];
	assign u_ok = !inst[11];
	assign b_ok = !inst[19] && !inst[24];

	// ------------------------------------------------------------
	// immediates
	// ------------------------------------------------------------
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	assign src1 = pick_operand(rs1, rdata1, ex_bypass, wb_bypass);
	assign src2 = pick_operand(rs2, rdata2, ex_bypass, wb_bypass);

	always_comb begin
		out_pkt = '0;
		out_pkt.pc = in_pkt.pc;
		out_pkt.rd = inst[10:7];
		out_pkt.alu_op = core_pkg::alu_add;
		use_imm = 1'b0;
		imm_sel = imm_i;
		case (opcode)
			core_pkg::opc_op: begin
				out_pkt.reg_write = r_ok;
				case ({funct7, funct3})
					10'b0000000_000: out_pkt.alu_op = core_pkg::alu_add;
					10'b0100000_000: out_pkt.alu_op = core_pkg::alu_sub;
					10'b0000000_111: out_pkt.alu_op = core_pkg::alu_and;
					10'b0000000_110: out_pkt.alu_op = core_pkg::alu_or;
					10'b0000000_100: out_pkt.alu_op = core_pkg::alu_xor;
					default: out_pkt.reg_write = 1'b0;
				endcase
			end
			core_pkg::opc_op_imm: begin
				// addi only
				out_pkt.reg_write = i_ok && (funct3 == 3'b000);
				use_imm = 1'b1;
			end
			core_pkg::opc_lui: begin
				out_pkt.reg_write = u_ok;
				out_pkt.alu_op = core_pkg::alu_pass_b;
				use_imm = 1'b1;
				imm_sel = imm_u;
			end
			core_pkg::opc_jal: begin
				out_pkt.reg_write = u_ok;
				out_pkt.is_jal = u_ok;
				imm_sel = imm_j;
			end
			core_pkg::opc_branch: begin
				out_pkt.is_branch = b_ok && (funct3[2:1] == 2'b00);
				out_pkt.branch_ne = funct3[0];
				imm_sel = imm_b;
			end
			default: begin
				// unknown word goes down the pipe as no-write
				out_pkt.reg_write = 1'b0;
			end
		endcase
		out_pkt.operand_a = src1;
		out_pkt.operand_b = use_imm ? imm_sel : src2;
		out_pkt.branch_rhs = src2;
		out_pkt.imm = imm_sel;
	end

endmodule

// ==== hw/execute_unit.sv ====
module execute_unit (
	input  logic                in_valid,
	output logic                in_ready,
	input  core_pkg::exec_pkt_t in_pkt,
	output logic                out_valid,
	input  logic                out_ready,
	output core_pkg::wb_pkt_t   out_pkt,
	output core_pkg::bypass_t   ex_bypass,
	output logic                flush,
	output core_pkg::addr_t     flush_target
);
	core_pkg::word_t alu_result;
	core_pkg::word_t result;
	logic            operands_equal;
	logic            taken;

	assign in_ready = out_ready;
	assign out_valid = in_valid;

	// ------------------------------------------------------------
	// alu
	// ------------------------------------------------------------
	always_comb begin
		case (in_pkt.alu_op)
			core_pkg::alu_add: alu_result = in_pkt.operand_a + in_pkt.operand_b;
			core_pkg::alu_sub: alu_result = in_pkt.operand_a - in_pkt.operand_b;
			core_pkg::alu_and: alu_result = in_pkt.operand_a & in_pkt.operand_b;
			core_pkg::alu_or: alu_result = in_pkt.operand_a | in_pkt.operand_b;
			core_pkg::alu_xor: alu_result = in_pkt.operand_a ^ in_pkt.operand_b;
			default: alu_result = in_pkt.operand_b;
		endcase
	end

	// link address for jal
	assign result = in_pkt.is_jal ? in_pkt.pc + 32'd4 : alu_result;

	// ------------------------------------------------------------
	// branch resolution
	// ------------------------------------------------------------
	assign operands_equal = (in_pkt.operand_a == in_pkt.branch_rhs);
	assign taken = in_pkt.is_jal || (in_pkt.is_branch && (operands_equal ^ in_pkt.branch_ne));

	// only when the redirecting instruction really moves on
	assign flush = in_valid && in_ready && taken;
	assign flush_target = in_pkt.pc + in_pkt.imm;

	assign out_pkt.pc = in_pkt.pc;
	assign out_pkt.rd = in_pkt.rd;
	assign out_pkt.reg_write = in_pkt.reg_write;
	assign out_pkt.result = result;

	assign ex_bypass.valid = in_valid && in_pkt.reg_write;
	assign ex_bypass.rd = in_pkt.rd;
	assign ex_bypass.data = result;

endmodule

// ==== hw/rv_core.sv ====
module rv_core (
	input  logic                clock,
	input  logic                arst_n,
	output logic                ar_valid,
	output core_pkg::addr_t     ar_addr,
	input  logic                ar_ready,
	input  logic                r_valid,
	input  core_pkg::word_t     r_data,
	input  core_pkg::axi_resp_t r_resp,
	output logic                r_ready,
	output core_pkg::retire_t   retire
);
	logic                 fetch_valid;
	logic                 fetch_ready;
	core_pkg::fetch_pkt_t fetch_pkt;
	logic                 ifid_valid;
	logic                 ifid_ready;
	core_pkg::fetch_pkt_t ifid_pkt;
	logic                 dec_valid;
	logic                 dec_ready;
	core_pkg::exec_pkt_t  dec_pkt;
	logic                 idex_valid;
	logic                 idex_ready;
	core_pkg::exec_pkt_t  idex_pkt;
	logic                 ex_valid;
	logic                 ex_ready;
	core_pkg::wb_pkt_t    ex_pkt;
	logic                 exwb_valid;
	core_pkg::wb_pkt_t    exwb_pkt;
	core_pkg::bypass_t    ex_bypass;
	core_pkg::bypass_t    wb_bypass;
	core_pkg::reg_id_t    rs1;
	core_pkg::reg_id_t    rs2;
	core_pkg::word_t      rdata1;
	core_pkg::word_t      rdata2;
	logic                 flush;
	core_pkg::addr_t      flush_target;

	fetch_unit u_fetch (
		.clock(clock), .arst_n(arst_n), .flush(flush), .flush_target(flush_target),
		.ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_data(r_data), .r_resp(r_resp), .r_ready(r_ready),
		.out_valid(fetch_valid), .out_ready(fetch_ready), .out_pkt(fetch_pkt)
	);

	pipe_stage #(.width($bits(core_pkg::fetch_pkt_t))) u_ifid (
		.clock(clock), .arst_n(arst_n), .flush(flush),
		.in_valid(fetch_valid), .in_ready(fetch_ready), .in_data(fetch_pkt),
		.out_valid(ifid_valid), .out_ready(ifid_ready), .out_data(ifid_pkt)
	);

	decode_unit u_decode (
		.in_valid(ifid_valid), .in_ready(ifid_ready), .in_pkt(ifid_pkt),
		.rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
		.ex_bypass(ex_bypass), .wb_bypass(wb_bypass),
		.out_valid(dec_valid), .out_ready(dec_ready), .out_pkt(dec_pkt)
	);

	pipe_stage #(.width($bits(core_pkg::exec_pkt_t))) u_idex (
		.clock(clock), .arst_n(arst_n), .flush(flush),
		.in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec_pkt),
		.out_valid(idex_valid), .out_ready(idex_ready), .out_data(idex_pkt)
	);

	execute_unit u_execute (
		.in_valid(idex_valid), .in_ready(idex_ready), .in_pkt(idex_pkt),
		.out_valid(ex_valid), .out_ready(ex_ready), .out_pkt(ex_pkt),
		.ex_bypass(ex_bypass), .flush(flush), .flush_target(flush_target)
	);

	// holds the redirecting instruction itself, never flushed; retire is always ready
	pipe_stage #(.width($bits(core_pkg::wb_pkt_t))) u_exwb (
		.clock(clock), .arst_n(arst_n), .flush(1'b0),
		.in_valid(ex_valid), .in_ready(ex_ready), .in_data(ex_pkt),
		.out_valid(exwb_valid), .out_ready(1'b1), .out_data(exwb_pkt)
	);

	reg_file u_regs (
		.clock(clock), .arst_n(arst_n), .rs1(rs1), .rs2(rs2),
		.rdata1(rdata1), .rdata2(rdata2),
		.we(exwb_valid && exwb_pkt.reg_write), .wa(exwb_pkt.rd), .wd(exwb_pkt.result)
	);

	// ------------------------------------------------------------
	// writeback
	// ------------------------------------------------------------
	assign wb_bypass.valid = exwb_valid && exwb_pkt.reg_write;
	assign wb_bypass.rd = exwb_pkt.rd;
	assign wb_bypass.data = exwb_pkt.result;

	assign retire.valid = exwb_valid;
	assign retire.pc = exwb_pkt.pc;
	assign retire.rd = exwb_pkt.rd;
	assign retire.reg_write = exwb_pkt.reg_write;
	assign retire.data = exwb_pkt.result;

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
	input  logic reset_req,
	output logic clock,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 10;

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// low from time zero, and again each time reset_req rises
	initial begin
		arst_n = 1'b0;
		forever begin
			repeat (reset_cycles) @(posedge clock);
			#1 arst_n = 1'b1;
			@(posedge reset_req);
			arst_n = 1'b0;
		end
	end

endmodule

// ==== verification/imem_model.sv ====
module imem_model (
	input  logic                clock,
	input  logic                arst_n,
	input  logic                random_delays,
	input  logic                ar_valid,
	input  core_pkg::addr_t     ar_addr,
	output logic                ar_ready,
	output logic                r_valid,
	output core_pkg::word_t     r_data,
	output core_pkg::axi_resp_t r_resp,
	input  logic                r_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 256;
	localparam logic [15:0] lfsr_seed = 16'd27535;

	core_pkg::inst_t mem [depth];
	logic [15:0]     lfsr_state;
	logic            busy;
	logic            resp_valid;
	logic [1:0]      wait_left;
	core_pkg::addr_t read_addr;
	logic            next_ar_ready;

	// fibonacci form, x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int count, output logic [1:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[0], lfsr_state[0]};
		end
	endtask

	initial begin
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		r_resp = core_pkg::axi_okay;
		busy = 1'b0;
		resp_valid = 1'b0;
		wait_left = '0;
		read_addr = '0;
		next_ar_ready = 1'b0;
		lfsr_state = lfsr_seed;
	end

	// ------------------------------------------------------------
	// handshakes seen at the edge, outputs change 1 ns later
	// ------------------------------------------------------------
	always @(posedge clock) begin
		logic [1:0] bits;
		bits = '0;
		if (!arst_n) begin
			busy = 1'b0;
			resp_valid = 1'b0;
			wait_left = '0;
			next_ar_ready = 1'b0;
			lfsr_state = lfsr_seed;
		end else begin
			if (r_valid && r_ready) begin
				busy = 1'b0;
				resp_valid = 1'b0;
			end
			if (ar_valid && ar_ready) begin
				busy = 1'b1;
				read_addr = ar_addr;
				if (random_delays) begin
					take_bits(2, bits);
				end
				wait_left = bits;
			end
			if (busy && !resp_valid) begin
				if (wait_left == '0) begin
					resp_valid = 1'b1;
				end else begin
					wait_left = wait_left - 2'd1;
				end
			end
			// one read at a time
			next_ar_ready = !busy;
			if (random_delays && !busy) begin
				take_bits(1, bits);
				next_ar_ready = bits[0];
			end
		end
		#1;
		ar_ready = next_ar_ready;
		r_valid = resp_valid;
		r_data = resp_valid ? mem[read_addr[9:2]] : '0;
		r_resp = core_pkg::axi_okay;
	end

endmodule

// ==== verification/core_tb.sv ====
module core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_timeout = 40;
	localparam int retire_timeout = 600;

	// funct7 and funct3 of the register-register operations
	localparam logic [9:0] op_add = 10'b0000000_000;
	localparam logic [9:0] op_sub = 10'b0100000_000;
	localparam logic [9:0] op_and = 10'b0000000_111;
	localparam logic [9:0] op_or = 10'b0000000_110;
	localparam logic [9:0] op_xor = 10'b0000000_100;

	logic                clock;
	logic                arst_n;
	logic                reset_req;
	logic                random_delays;
	logic                ar_valid;
	core_pkg::addr_t     ar_addr;
	logic                ar_ready;
	logic                r_valid;
	core_pkg::word_t     r_data;
	core_pkg::axi_resp_t r_resp;
	logic                r_ready;
	core_pkg::retire_t   retire;

	core_pkg::inst_t     prog[$];
	core_pkg::retire_t   records[$];
	int                  error_count;
	int                  check_count;
	int                  test_count;

	tb_clock u_clock (.reset_req(reset_req), .clock(clock), .arst_n(arst_n));

	imem_model u_mem (
		.clock(clock), .arst_n(arst_n), .random_delays(random_delays),
		.ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_data(r_data), .r_resp(r_resp), .r_ready(r_ready)
	);

	rv_core u_dut (
		.clock(clock), .arst_n(arst_n),
		.ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_data(r_data), .r_resp(r_resp), .r_ready(r_ready),
		.retire(retire)
	);

	// retire port sampled on the edge, before exwb moves on
	always @(posedge clock) begin
		if (arst_n && retire.valid) begin
			records.push_back(retire);
		end
	end

	// ------------------------------------------------------------
	// instruction encodings
	// ------------------------------------------------------------
	function automatic core_pkg::inst_t r_type_word(input logic [9:0] op,
		input core_pkg::reg_id_t rd, input core_pkg::reg_id_t rs1, input core_pkg::reg_id_t rs2);
		return {op[9:3], 1'b0, rs2, 1'b0, rs1, op[2:0], 1'b0, rd, 7'b0110011};
	endfunction

	function automatic core_pkg::inst_t addi_word(input core_pkg::reg_id_t rd,
		input core_pkg::reg_id_t rs1, input logic [11:0] imm);
		return {imm, 1'b0, rs1, 3'b000, 1'b0, rd, 7'b0010011};
	endfunction

	function automatic core_pkg::inst_t lui_word(input core_pkg::reg_id_t rd,
		input logic [19:0] imm);
		return {imm, 1'b0, rd, 7'b0110111};
	endfunction

	function automatic core_pkg::inst_t jal_word(input core_pkg::reg_id_t rd,
		input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, 7'b1101111};
	endfunction

	// funct3 000 is beq, 001 is bne
	function automatic core_pkg::inst_t branch_word(input logic [2:0] funct3,
		input core_pkg::reg_id_t rs1, input core_pkg::reg_id_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, funct3, off[4:1], off[11],
			7'b1100011};
	endfunction

	function automatic core_pkg::addr_t pc_at(input int idx);
		return core_pkg::reset_pc + core_pkg::addr_t'(idx * 4);
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input core_pkg::word_t actual, input core_pkg::word_t expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_reg(input core_pkg::reg_id_t actual, input core_pkg::reg_id_t expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s is x%0d, expected x%0d", $time, what, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic check_addr(input core_pkg::addr_t actual, input core_pkg::addr_t expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		check_count++;
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
			error_count++;
		end
	endtask

	// rd and data only matter for a register write
	task automatic verify_record(input int idx, input core_pkg::addr_t pc, input logic reg_write,
		input core_pkg::reg_id_t rd, input core_pkg::word_t data);
		string tag;
		tag = $sformatf("record %0d", idx);
		if (idx >= records.size()) begin
			$display("error: %s is missing, only %0d instructions retired", tag, records.size());
			error_count++;
		end else begin
			check_addr(records[idx].pc, pc, {tag, " pc"});
			check_flag(records[idx].reg_write, reg_write, {tag, " reg_write"});
			if (reg_write) begin
				check_reg(records[idx].rd, rd, {tag, " rd"});
				check_word(records[idx].data, data, {tag, " data"});
			end
		end
	endtask

	// ------------------------------------------------------------
	// program load, reset and retire collection
	// ------------------------------------------------------------
	task automatic run_program(input int expected_count, input logic use_random);
		int waited;
		core_pkg::addr_t addr;
		@(posedge clock);
		#1;
		reset_req = 1'b1;
		random_delays = use_random;
		// unused words get a no-write encoding marked with their own index
		for (int i = 0; i < 256; i++) begin
			u_mem.mem[i] = {i[7:0], i[7:0], i[7:0], 8'h0b};
		end
		foreach (prog[i]) begin
			addr = pc_at(i);
			u_mem.mem[addr[9:2]] = prog[i];
		end
		records.delete();
		@(posedge clock);
		#1;
		reset_req = 1'b0;
		// bus and retire outputs quiet while reset is held
		check_flag(ar_valid, 1'b0, "ar_valid in reset");
		check_flag(r_ready, 1'b0, "r_ready in reset");
		check_flag(retire.valid, 1'b0, "retire valid in reset");
		waited = 0;
		while (!arst_n && waited < reset_timeout) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!arst_n) begin
			$display("error: reset still active after %0d cycles", reset_timeout);
			error_count++;
		end
		waited = 0;
		while (!ar_valid && waited < reset_timeout) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!ar_valid) begin
			$display("error: no fetch request within %0d cycles after reset", reset_timeout);
			error_count++;
		end else begin
			check_addr(ar_addr, core_pkg::reset_pc, "first fetch address");
		end
		waited = 0;
		while (records.size() < expected_count && waited < retire_timeout) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (records.size() < expected_count) begin
			$display("error: timed out after %0d cycles with %0d of %0d instructions retired",
				retire_timeout, records.size(), expected_count);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic alu_independent();
		int errors_before;
		errors_before = error_count;
		prog.delete();
		prog.push_back(addi_word(4'd1, 4'd0, 12'h5a3));
		prog.push_back(addi_word(4'd2, 4'd0, 12'hff0));   // -16
		prog.push_back(lui_word(4'd3, 20'habcde));
		prog.push_back(r_type_word(op_add, 4'd4, 4'd1, 4'd2));
		prog.push_back(r_type_word(op_sub, 4'd5, 4'd1, 4'd2));
		prog.push_back(r_type_word(op_and, 4'd6, 4'd1, 4'd2));
		prog.push_back(r_type_word(op_or, 4'd7, 4'd1, 4'd3));
		prog.push_back(r_type_word(op_xor, 4'd8, 4'd2, 4'd3));
		run_program(8, 1'b0);
		verify_record(0, pc_at(0), 1'b1, 4'd1, 32'h0000_05a3);
		verify_record(1, pc_at(1), 1'b1, 4'd2, 32'hffff_fff0);
		verify_record(2, pc_at(2), 1'b1, 4'd3, 32'habcd_e000);
		verify_record(3, pc_at(3), 1'b1, 4'd4, 32'h0000_0593);
		verify_record(4, pc_at(4), 1'b1, 4'd5, 32'h0000_05b3);
		verify_record(5, pc_at(5), 1'b1, 4'd6, 32'h0000_05a0);
		verify_record(6, pc_at(6), 1'b1, 4'd7, 32'habcd_e5a3);
		verify_record(7, pc_at(7), 1'b1, 4'd8, 32'h5432_1ff0);
		report_test("alu_independent", errors_before);
	endtask

	task automatic build_chain_program();
		prog.delete();
		prog.push_back(addi_word(4'd1, 4'd0, 12'd7));
		prog.push_back(addi_word(4'd2, 4'd1, 12'd3));
		prog.push_back(r_type_word(op_add, 4'd3, 4'd2, 4'd1));
		prog.push_back(r_type_word(op_sub, 4'd4, 4'd3, 4'd2));
		prog.push_back(r_type_word(op_xor, 4'd5, 4'd4, 4'd3));
		prog.push_back(r_type_word(op_add, 4'd5, 4'd5, 4'd5));
		prog.push_back(r_type_word(op_or, 4'd6, 4'd5, 4'd4));
	endtask

	// isa results of the chain program
	task automatic expect_chain_results();
		verify_record(0, pc_at(0), 1'b1, 4'd1, 32'd7);
		verify_record(1, pc_at(1), 1'b1, 4'd2, 32'd10);
		verify_record(2, pc_at(2), 1'b1, 4'd3, 32'd17);
		verify_record(3, pc_at(3), 1'b1, 4'd4, 32'd7);
		verify_record(4, pc_at(4), 1'b1, 4'd5, 32'h16);
		verify_record(5, pc_at(5), 1'b1, 4'd5, 32'h2c);
		verify_record(6, pc_at(6), 1'b1, 4'd6, 32'h2f);
	endtask

	task automatic dependency_chain();
		int errors_before;
		errors_before = error_count;
		build_chain_program();
		run_program(7, 1'b0);
		expect_chain_results();
		report_test("dependency_chain", errors_before);
	endtask

	task automatic taken_redirects();
		int errors_before;
		errors_before = error_count;
		prog.delete();
		prog.push_back(addi_word(4'd1, 4'd0, 12'd5));
		prog.push_back(addi_word(4'd2, 4'd0, 12'd5));
		prog.push_back(branch_word(3'b000, 4'd1, 4'd2, 13'd12));
		prog.push_back(addi_word(4'd3, 4'd0, 12'd1));
		prog.push_back(addi_word(4'd3, 4'd0, 12'd2));
		prog.push_back(branch_word(3'b001, 4'd1, 4'd0, 13'd12));
		prog.push_back(addi_word(4'd4, 4'd0, 12'd1));
		prog.push_back(addi_word(4'd4, 4'd0, 12'd2));
		prog.push_back(jal_word(4'd5, 21'd12));
		prog.push_back(addi_word(4'd6, 4'd0, 12'd1));
		prog.push_back(addi_word(4'd6, 4'd0, 12'd2));
		prog.push_back(addi_word(4'd7, 4'd5, 12'd1));
		run_program(6, 1'b0);
		verify_record(0, pc_at(0), 1'b1, 4'd1, 32'd5);
		verify_record(1, pc_at(1), 1'b1, 4'd2, 32'd5);
		verify_record(2, pc_at(2), 1'b0, 4'd0, 32'd0);
		verify_record(3, pc_at(5), 1'b0, 4'd0, 32'd0);
		verify_record(4, pc_at(8), 1'b1, 4'd5, pc_at(8) + 32'd4);
		verify_record(5, pc_at(11), 1'b1, 4'd7, pc_at(8) + 32'd5);
		report_test("taken_redirects", errors_before);
	endtask

	task automatic fallthrough_branches();
		int errors_before;
		errors_before = error_count;
		prog.delete();
		prog.push_back(addi_word(4'd1, 4'd0, 12'd3));
		prog.push_back(addi_word(4'd2, 4'd0, 12'd4));
		prog.push_back(branch_word(3'b000, 4'd1, 4'd2, 13'd16));
		prog.push_back(branch_word(3'b001, 4'd1, 4'd1, 13'd16));
		prog.push_back(addi_word(4'd3, 4'd1, 12'd1));
		prog.push_back(branch_word(3'b001, 4'd2, 4'd3, 13'd8));
		prog.push_back(addi_word(4'd4, 4'd0, 12'd9));
		run_program(7, 1'b0);
		verify_record(0, pc_at(0), 1'b1, 4'd1, 32'd3);
		verify_record(1, pc_at(1), 1'b1, 4'd2, 32'd4);
		verify_record(2, pc_at(2), 1'b0, 4'd0, 32'd0);
		verify_record(3, pc_at(3), 1'b0, 4'd0, 32'd0);
		verify_record(4, pc_at(4), 1'b1, 4'd3, 32'd4);
		verify_record(5, pc_at(5), 1'b0, 4'd0, 32'd0);
		verify_record(6, pc_at(6), 1'b1, 4'd4, 32'd9);
		report_test("fallthrough_branches", errors_before);
	endtask

	task automatic zero_reg_and_unknown();
		int errors_before;
		errors_before = error_count;
		prog.delete();
		prog.push_back(addi_word(4'd0, 4'd0, 12'h055));
		prog.push_back(addi_word(4'd1, 4'd0, 12'h011));
		prog.push_back(r_type_word(op_add, 4'd2, 4'd0, 4'd1));
		prog.push_back(32'hffff_ffff);
		prog.push_back(32'h0000_0000);
		prog.push_back(r_type_word(op_or, 4'd3, 4'd0, 4'd0));
		prog.push_back(r_type_word(op_sub, 4'd4, 4'd1, 4'd0));
		run_program(7, 1'b0);
		// a write to x0 may still show reg_write, but then only with rd zero
		if (records.size() > 0) begin
			check_addr(records[0].pc, pc_at(0), "record 0 pc");
			if (records[0].reg_write) begin
				check_reg(records[0].rd, 4'd0, "record 0 rd");
			end
		end
		verify_record(1, pc_at(1), 1'b1, 4'd1, 32'h11);
		verify_record(2, pc_at(2), 1'b1, 4'd2, 32'h11);
		verify_record(3, pc_at(3), 1'b0, 4'd0, 32'd0);
		verify_record(4, pc_at(4), 1'b0, 4'd0, 32'd0);
		verify_record(5, pc_at(5), 1'b1, 4'd3, 32'd0);
		verify_record(6, pc_at(6), 1'b1, 4'd4, 32'h11);
		report_test("zero_reg_and_unknown", errors_before);
	endtask

	task automatic memory_backpressure();
		int errors_before;
		errors_before = error_count;
		build_chain_program();
		run_program(7, 1'b1);
		expect_chain_results();
		report_test("memory_backpressure", errors_before);
	endtask

	initial begin
		reset_req = 1'b0;
		random_delays = 1'b0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		alu_independent();
		dependency_chain();
		taken_redirects();
		fallthrough_branches();
		zero_reg_and_unknown();
		memory_backpressure();
		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
hw/core_pkg.sv
hw/pipe_stage.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/rv_core.sv
verification/tb_clock.sv
verification/imem_model.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_tb -f compile.f \
	-Mdir obj_dir -o core_tb_sim
./obj_dir/core_tb_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation reported errors"
	exit 1
fi
